/* dv/eth_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_core_tb import eth_pkg::*; ();

   localparam int clk_period   = 40;
   localparam int n_rows       = 5;
   localparam int kind_own     = 0;
   localparam int kind_bcast   = 1;
   localparam int kind_other   = 2;
   localparam int max_polls    = 200;
   localparam int idle_span    = 40;
   localparam int row_margin   = 1500;
   localparam int reset_margin = 600;
   localparam logic [47:0] other_addr = 48'h02_1a_2b_3c_4d_5e;

   // First row relies on the reset frame length of 46
   int row_kind   [n_rows] = '{kind_own, kind_other, kind_bcast, kind_own, kind_bcast};
   int row_len    [n_rows] = '{46, 50, 61, 64, 53};
   bit row_setlen [n_rows] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1};

   logic              clk;
   logic              mii_clk;
   logic              rst_int;
   logic              valid;
   logic [3:0]        wstrb;
   logic [addr_w-1:0] addr;
   logic [31:0]       data_in;
   logic              ready;
   logic [31:0]       data_out;
   logic              phy_resetn;
   logic              tx_en;
   logic [3:0]        tx_data;
   logic [3:0]        rx_data;
   logic              rx_dv;

   logic [7:0] frame [128];
   int         errors = 0;
   int         checks = 0;

   initial clk = 1'b0;
   always #(clk_period / 2) clk = ~clk;

   // MII clock trails clk by 7 ns
   initial mii_clk = 1'b0;
   always @(clk) mii_clk <= #7 clk;

   // MII loopback
   assign rx_data = tx_data;
   assign rx_dv   = tx_en;

   eth_core UUT (
      .clk        (clk),
      .rst_int    (rst_int),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .data_in    (data_in),
      .ready      (ready),
      .data_out   (data_out),
      .phy_resetn (phy_resetn),
      .tx_clk     (mii_clk),
      .tx_en      (tx_en),
      .tx_data    (tx_data),
      .rx_clk     (mii_clk),
      .rx_data    (rx_data),
      .rx_dv      (rx_dv)
   );

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_status(input string name, input logic [2:0] got,
                               input logic [2:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic bus_write(input logic [addr_w-1:0] a, input logic [31:0] d);
      @(posedge clk);
      valid   <= 1'b1;
      wstrb   <= 4'hf;
      addr    <= a;
      data_in <= d;
      @(posedge clk);
      valid   <= 1'b0;
      wstrb   <= 4'h0;
   endtask

   // Two valid cycles so a buffer word has come out of the memory
   task automatic bus_read(input logic [addr_w-1:0] a, output logic [31:0] d);
      @(posedge clk);
      valid <= 1'b1;
      wstrb <= 4'h0;
      addr  <= a;
      @(negedge clk);
      check_word("ready", 32'(ready), 32'h0);
      @(posedge clk);
      @(negedge clk);
      check_word("ready", 32'(ready), 32'h1);
      d = data_out;
      @(posedge clk);
      valid <= 1'b0;
   endtask

   task automatic wait_status(input int bit_pos, input logic level, input string what);
      logic [31:0] d;
      int          polls;
      polls = 0;
      bus_read(eth_status, d);
      while (d[bit_pos] !== level && polls < max_polls) begin
         bus_read(eth_status, d);
         polls++;
      end
      checks++;
      if (d[bit_pos] !== level) begin
         errors++;
         $display("Timed out polling the status register for %s", what);
      end
   endtask

   function automatic logic [7:0] dest_byte(input int kind, input int b);
      logic [47:0] a;
      case (kind)
         kind_own:   a = eth_mac_addr;
         kind_bcast: a = eth_bcast_addr;
         default:    a = other_addr;
      endcase
      return a[47 - 8 * b -: 8];
   endfunction

   // Destination bytes then random payload with byte 0 in the low lane
   task automatic load_frame(input int kind, input int len);
      for (int b = 0; b < 128; b++)
         frame[b] = (b < 6) ? dest_byte(kind, b) : ((b < len) ? 8'($urandom) : 8'h00);
      for (int w = 0; w < (len + 3) / 4; w++)
         bus_write(addr_w'(12'h800 + 4 * w),
                   {frame[4 * w + 3], frame[4 * w + 2], frame[4 * w + 1], frame[4 * w]});
   endtask

   task automatic check_rx_frame(input int len);
      logic [31:0] d;
      logic [31:0] exp_w;
      logic [31:0] mask;
      bus_read(eth_rcv_size, d);
      check_word("eth_rcv_size", d, 32'(len + 4));
      // FCS bytes are left to the residue check
      for (int w = 0; w < (len + 3) / 4; w++) begin
         exp_w = {frame[4 * w + 3], frame[4 * w + 2], frame[4 * w + 1], frame[4 * w]};
         mask  = '0;
         for (int b = 0; b < 4; b++)
            if (4 * w + b < len)
               mask[8 * b +: 8] = 8'hff;
         bus_read(addr_w'(12'h800 + 4 * w), d);
         check_word($sformatf("rx word %0d", w), d & mask, exp_w & mask);
      end
      bus_read(eth_crc, d);
      check_word("eth_crc", d, crc_residue);
   endtask

   initial begin : watchdog
      longint span;
      span = reset_margin;
      for (int r = 0; r < n_rows; r++)
         span += 2 * (row_len[r] + 12) + row_margin;
      #(span * clk_period);
      $display("Watchdog expired after %0d ns, the DUT never finished", span * clk_period);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin : main
      logic [31:0] d;
      logic [31:0] scratch;
      longint      t_rel;
      rst_int = 1'b1;
      valid   = 1'b0;
      wstrb   = 4'h0;
      addr    = '0;
      data_in = '0;
      void'($urandom(32'h9bf6));
      repeat (3) @(posedge clk);
      rst_int <= 1'b0;
      t_rel = $time;

      @(negedge clk);
      check_word("tx_en", 32'(tx_en), 32'h0);
      check_word("phy_resetn", 32'(phy_resetn), 32'h0);
      check_word("ready", 32'(ready), 32'h0);
      bus_read(eth_status, d);
      check_status("status during PHY reset", d[2:0], 3'b000);
      @(posedge phy_resetn);
      check_word("phy reset cycles", 32'(($time - t_rel) / clk_period), phy_rst_cycles + 1);
      repeat (2) @(posedge clk);
      bus_read(eth_status, d);
      check_status("status after PHY reset", d[2:0], 3'b101);

      // Scratch register
      scratch = $urandom;
      bus_write(eth_dummy, scratch);
      bus_read(eth_dummy, d);
      check_word("eth_dummy", d, scratch);

      for (int row = 0; row < n_rows; row++) begin
         load_frame(row_kind[row], row_len[row]);
         if (row_setlen[row])
            bus_write(eth_tx_nbytes, 32'(row_len[row]));
         bus_write(eth_send, 32'h1);
         wait_status(st_tx_ready, 1'b0, $sformatf("tx_ready to fall in row %0d", row));
         wait_status(st_tx_ready, 1'b1, $sformatf("tx_ready to return in row %0d", row));
         if (row_kind[row] != kind_other) begin
            wait_status(st_data_rcvd, 1'b1, $sformatf("data_rcvd in row %0d", row));
            check_rx_frame(row_len[row]);
            bus_write(eth_rcvack, 32'h1);
            wait_status(st_data_rcvd, 1'b0, $sformatf("data_rcvd to clear in row %0d", row));
         end else begin
            repeat (idle_span) @(posedge clk);
            bus_read(eth_status, d);
            check_status($sformatf("status after foreign frame, row %0d", row),
                         d[2:0], 3'b101);
         end
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/eth_core.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_core import eth_pkg::*; (
   input  wire               clk,
   input  wire               rst_int,
   input  wire               valid,
   input  wire [3:0]         wstrb,
   input  wire [addr_w-1:0]  addr,
   input  wire [31:0]        data_in,
   output logic              ready,
   output logic [31:0]       data_out,
   output logic              phy_resetn,
   input  wire               tx_clk,
   output logic              tx_en,
   output logic [3:0]        tx_data,
   input  wire               rx_clk,
   input  wire [3:0]         rx_data,
   input  wire               rx_dv
);

   logic                tx_buf_we;
   logic [buf_aw-1:0]   tx_buf_addr;
   buf_word_t           tx_buf_wdata;
   logic [buf_aw-1:0]   tx_rd_addr;
   buf_word_t           tx_rd_data;
   logic [buf_aw-1:0]   rx_buf_addr;
   buf_word_t           rx_buf_rdata;
   logic                rx_wr_en;
   logic [buf_aw-1:0]   rx_wr_addr;
   buf_word_t           rx_wr_data;
   logic                send_req;
   logic                rcvack_req;
   logic                send;
   logic                rcv_ack;
   logic [nbytes_w-1:0] tx_nbytes;
   logic                tx_ready_raw;
   logic                data_rcvd_raw;
   logic [31:0]         crc_raw;
   logic [nbytes_w-1:0] rx_size_raw;

   eth_regs regs (
      .clk           (clk),
      .rst_int       (rst_int),
      .valid         (valid),
      .wstrb         (wstrb),
      .addr          (addr),
      .data_in       (data_in),
      .ready         (ready),
      .data_out      (data_out),
      .tx_buf_we     (tx_buf_we),
      .tx_buf_addr   (tx_buf_addr),
      .tx_buf_wdata  (tx_buf_wdata),
      .rx_buf_addr   (rx_buf_addr),
      .send_req      (send_req),
      .rcvack_req    (rcvack_req),
      .tx_nbytes     (tx_nbytes),
      .phy_resetn    (phy_resetn),
      .rx_buf_rdata  (rx_buf_rdata),
      .tx_ready_raw  (tx_ready_raw),
      .data_rcvd_raw (data_rcvd_raw),
      .crc_raw       (crc_raw),
      .rx_size_raw   (rx_size_raw)
   );

   // CPU writes, transmitter reads
   eth_dp_mem tx_buffer (
      .wclk  (clk),
      .we    (tx_buf_we),
      .waddr (tx_buf_addr),
      .wdata (tx_buf_wdata),
      .rclk  (tx_clk),
      .raddr (tx_rd_addr),
      .rdata (tx_rd_data)
   );

   // Receiver writes, CPU reads
   eth_dp_mem rx_buffer (
      .wclk  (rx_clk),
      .we    (rx_wr_en),
      .waddr (rx_wr_addr),
      .wdata (rx_wr_data),
      .rclk  (clk),
      .raddr (rx_buf_addr),
      .rdata (rx_buf_rdata)
   );

   eth_pulse_sync send_sync (
      .clk       (clk),
      .rst_int   (rst_int),
      .pulse_in  (send_req),
      .dst_clk   (tx_clk),
      .pulse_out (send)
   );

   eth_pulse_sync rcvack_sync (
      .clk       (clk),
      .rst_int   (rst_int),
      .pulse_in  (rcvack_req),
      .dst_clk   (rx_clk),
      .pulse_out (rcv_ack)
   );

   eth_tx tx (
      .tx_clk  (tx_clk),
      .rst_int (rst_int),
      .send    (send),
      .nbytes  (tx_nbytes),
      .rd_data (tx_rd_data),
      .rd_addr (tx_rd_addr),
      .ready   (tx_ready_raw),
      .tx_en   (tx_en),
      .tx_data (tx_data)
   );

   eth_rx rx (
      .rx_clk    (rx_clk),
      .rst_int   (rst_int),
      .rx_data   (rx_data),
      .rx_dv     (rx_dv),
      .rcv_ack   (rcv_ack),
      .wr_en     (rx_wr_en),
      .wr_addr   (rx_wr_addr),
      .wr_data   (rx_wr_data),
      .data_rcvd (data_rcvd_raw),
      .crc_value (crc_raw),
      .rx_size   (rx_size_raw)
   );

endmodule

`default_nettype wire

/* rtl/eth_dp_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_dp_mem import eth_pkg::*; (
   input  wire                wclk,
   input  wire                we,
   input  wire [buf_aw-1:0]   waddr,
   input  wire buf_word_t     wdata,
   input  wire                rclk,
   input  wire [buf_aw-1:0]   raddr,
   output buf_word_t          rdata
);

   buf_word_t mem [2**buf_aw];

   always_ff @(posedge wclk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Registered read, one cycle of rclk
   always_ff @(posedge rclk) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

/* rtl/eth_pkg.sv */
`default_nettype none

package eth_pkg;

   // CPU bus, bit 11 selects the buffers
   localparam int addr_w   = 12;
   localparam int buf_aw   = 9;
   localparam int nbytes_w = 11;

   // Register map
   localparam logic [addr_w-1:0] eth_status    = 12'h000;
   localparam logic [addr_w-1:0] eth_send      = 12'h004;
   localparam logic [addr_w-1:0] eth_rcvack    = 12'h008;
   localparam logic [addr_w-1:0] eth_dummy     = 12'h00c;
   localparam logic [addr_w-1:0] eth_tx_nbytes = 12'h010;
   localparam logic [addr_w-1:0] eth_crc       = 12'h014;
   localparam logic [addr_w-1:0] eth_rcv_size  = 12'h018;

   localparam logic [nbytes_w-1:0] tx_nbytes_rst = 11'd46;

   // Bits 47:40 go first on the wire
   localparam logic [47:0] eth_mac_addr   = 48'h01_60_6e_11_02_0f;
   localparam logic [47:0] eth_bcast_addr = 48'hff_ff_ff_ff_ff_ff;

   localparam int phy_rst_cycles = 255;

   // Reflected CRC-32
   localparam logic [31:0] crc_poly    = 32'hedb88320;
   localparam logic [31:0] crc_residue = 32'hc704dd7b;

   // Status bits
   localparam int st_tx_ready   = 0;
   localparam int st_data_rcvd  = 1;
   localparam int st_phy_resetn = 2;

   // Transmit FSM
   localparam logic [2:0] tx_st_idle = 3'd0;
   localparam logic [2:0] tx_st_pre  = 3'd1;
   localparam logic [2:0] tx_st_sfd  = 3'd2;
   localparam logic [2:0] tx_st_data = 3'd3;
   localparam logic [2:0] tx_st_fcs  = 3'd4;

   // Receive FSM
   localparam logic [1:0] rx_st_idle = 2'd0;
   localparam logic [1:0] rx_st_data = 2'd1;
   localparam logic [1:0] rx_st_skip = 2'd2;

   // Buffer word, byte 0 is the first byte on the wire
   typedef union packed {
      logic [31:0]     word;
      logic [3:0][7:0] bytes;
   } buf_word_t;

   // One nibble into the CRC, bit 0 first
   function automatic logic [31:0] crc32_nibble(input logic [31:0] crc,
                                                input logic [3:0]  nib);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 4; i++) begin
         if (c[0] ^ nib[i])
            c = (c >> 1) ^ crc_poly;
         else
            c = c >> 1;
      end
      return c;
   endfunction

endpackage

`default_nettype wire

/* rtl/eth_pulse_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_pulse_sync (
   input  wire   clk,
   input  wire   rst_int,
   input  wire   pulse_in,
   input  wire   dst_clk,
   output logic  pulse_out
);

   logic       toggle;
   logic [2:0] sync;

   // Each source pulse flips the level
   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int)
         toggle <= 1'b0;
      else if (pulse_in)
         toggle <= ~toggle;
   end

   always_ff @(posedge dst_clk, posedge rst_int) begin
      if (rst_int)
         sync <= '0;
      else
         sync <= {sync[1:0], toggle};
   end

   // Any change of the level is one pulse
   assign pulse_out = sync[2] ^ sync[1];

endmodule

`default_nettype wire

/* rtl/eth_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_regs import eth_pkg::*; (
   input  wire                 clk,
   input  wire                 rst_int,
   input  wire                 valid,
   input  wire [3:0]           wstrb,
   input  wire [addr_w-1:0]    addr,
   input  wire [31:0]          data_in,
   output logic                ready,
   output logic [31:0]         data_out,
   output logic                tx_buf_we,
   output logic [buf_aw-1:0]   tx_buf_addr,
   output buf_word_t           tx_buf_wdata,
   output logic [buf_aw-1:0]   rx_buf_addr,
   output logic                send_req,
   output logic                rcvack_req,
   output logic [nbytes_w-1:0] tx_nbytes,
   output logic                phy_resetn,
   input  wire buf_word_t      rx_buf_rdata,
   input  wire                 tx_ready_raw,
   input  wire                 data_rcvd_raw,
   input  wire [31:0]          crc_raw,
   input  wire [nbytes_w-1:0]  rx_size_raw
);

   logic [31:0]                            dummy;
   logic                                   dummy_en;
   logic                                   nbytes_en;
   logic [1:0]                             tx_ready_s;
   logic [1:0]                             data_rcvd_s;
   logic [31:0]                            crc_s [2];
   logic [nbytes_w-1:0]                    size_s [2];
   logic [$clog2(phy_rst_cycles+1)-1:0]    phy_cnt;

   // Buffer word index from bits 10..2
   assign tx_buf_addr       = addr[addr_w-2:2];
   assign rx_buf_addr       = addr[addr_w-2:2];
   assign tx_buf_wdata.word = data_in;

   // Write decode
   always_comb begin
      send_req   = 1'b0;
      rcvack_req = 1'b0;
      dummy_en   = 1'b0;
      nbytes_en  = 1'b0;
      tx_buf_we  = 1'b0;
      if (valid && |wstrb) begin
         if (addr[addr_w-1])
            tx_buf_we = 1'b1;
         else begin
            case (addr)
               eth_send:      send_req   = 1'b1;
               eth_rcvack:    rcvack_req = 1'b1;
               eth_dummy:     dummy_en   = 1'b1;
               eth_tx_nbytes: nbytes_en  = 1'b1;
               default: ;
            endcase
         end
      end
   end

   // Read mux
   always_comb begin
      data_out = '0;
      if (valid) begin
         if (addr[addr_w-1])
            data_out = rx_buf_rdata.word;
         else begin
            case (addr)
               eth_status: begin
                  data_out[st_tx_ready]   = tx_ready_s[1];
                  data_out[st_data_rcvd]  = data_rcvd_s[1];
                  data_out[st_phy_resetn] = phy_resetn;
               end
               eth_dummy:    data_out = dummy;
               eth_crc:      data_out = crc_s[1];
               eth_rcv_size: data_out = 32'(size_s[1]);
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         ready     <= 1'b0;
         dummy     <= '0;
         tx_nbytes <= tx_nbytes_rst;
      end else begin
         ready <= valid;
         if (dummy_en)
            dummy <= data_in;
         if (nbytes_en)
            tx_nbytes <= data_in[nbytes_w-1:0];
      end
   end

   // Status levels from the MII domains
   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         tx_ready_s  <= '0;
         data_rcvd_s <= '0;
      end else begin
         tx_ready_s  <= {tx_ready_s[0], tx_ready_raw & phy_resetn};
         data_rcvd_s <= {data_rcvd_s[0], data_rcvd_raw};
      end
   end

   // Settled long before data_rcvd shows up here
   always_ff @(posedge clk) begin
      crc_s[0]  <= crc_raw;
      crc_s[1]  <= crc_s[0];
      size_s[0] <= rx_size_raw;
      size_s[1] <= size_s[0];
   end

   // PHY held in reset after power up
   always_ff @(posedge clk, posedge rst_int) begin
      if (rst_int) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (phy_cnt != phy_rst_cycles)
         phy_cnt <= phy_cnt + 1'b1;
      else
         phy_resetn <= 1'b1;
   end

endmodule

`default_nettype wire

/* rtl/eth_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_rx import eth_pkg::*; (
   input  wire                 rx_clk,
   input  wire                 rst_int,
   input  wire [3:0]           rx_data,
   input  wire                 rx_dv,
   input  wire                 rcv_ack,
   output logic                wr_en,
   output logic [buf_aw-1:0]   wr_addr,
   output buf_word_t           wr_data,
   output logic                data_rcvd,
   output logic [31:0]         crc_value,
   output logic [nbytes_w-1:0] rx_size
);

   logic [1:0]          state;
   logic                hi;
   logic [3:0]          lo_nib;
   logic [nbytes_w-1:0] byte_cnt;
   logic [47:0]         mac_sr;
   logic                mac_ok;
   logic                bc_ok;
   logic [31:0]         crc;
   logic [7:0]          rx_byte;
   logic                mac_hit;
   logic                bc_hit;

   assign rx_byte = {rx_data, lo_nib};

   // Header byte still matches own or broadcast address
   assign mac_hit = mac_ok && (rx_byte == mac_sr[47:40]);
   assign bc_hit  = bc_ok && (rx_byte == eth_bcast_addr[47:40]);

   // Residue is checked in normal bit order
   assign crc_value = {<<{crc}};

   always_ff @(posedge rx_clk, posedge rst_int) begin
      if (rst_int) begin
         state     <= rx_st_idle;
         hi        <= 1'b0;
         lo_nib    <= '0;
         byte_cnt  <= '0;
         mac_sr    <= '0;
         mac_ok    <= 1'b0;
         bc_ok     <= 1'b0;
         crc       <= '1;
         wr_en     <= 1'b0;
         wr_addr   <= '0;
         wr_data   <= '0;
         data_rcvd <= 1'b0;
         rx_size   <= '0;
      end else begin
         wr_en <= 1'b0;
         if (rcv_ack)
            data_rcvd <= 1'b0;
         case (state)
            rx_st_idle: begin
               // A held frame blocks new ones
               if (rx_dv) begin
                  if (rx_data == 4'hd && !data_rcvd) begin
                     state    <= rx_st_data;
                     hi       <= 1'b0;
                     byte_cnt <= '0;
                     mac_sr   <= eth_mac_addr;
                     mac_ok   <= 1'b1;
                     bc_ok    <= 1'b1;
                     crc      <= '1;
                  end else if (rx_data != 4'h5 || data_rcvd)
                     state <= rx_st_skip;
               end
            end
            rx_st_data: begin
               if (!rx_dv) begin
                  state <= rx_st_idle;
                  if (byte_cnt > 11'd5)
                     data_rcvd <= 1'b1;
               end else begin
                  crc <= crc32_nibble(crc, rx_data);
                  hi  <= ~hi;
                  if (!hi)
                     lo_nib <= rx_data;
                  else begin
                     byte_cnt <= byte_cnt + 1'b1;
                     rx_size  <= byte_cnt + 1'b1;
                     // Partial word goes out after every byte
                     wr_en    <= 1'b1;
                     wr_addr  <= byte_cnt[nbytes_w-1:2];
                     if (byte_cnt[1:0] == 2'd0)
                        wr_data.word <= {24'd0, rx_byte};
                     else
                        wr_data.bytes[byte_cnt[1:0]] <= rx_byte;
                     if (byte_cnt < 11'd6) begin
                        mac_sr <= mac_sr << 8;
                        mac_ok <= mac_hit;
                        bc_ok  <= bc_hit;
                        if (!mac_hit && !bc_hit)
                           state <= rx_st_skip;
                     end
                  end
               end
            end
            rx_st_skip: begin
               if (!rx_dv)
                  state <= rx_st_idle;
            end
            default: state <= rx_st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/eth_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_tx import eth_pkg::*; (
   input  wire                 tx_clk,
   input  wire                 rst_int,
   input  wire                 send,
   input  wire [nbytes_w-1:0]  nbytes,
   input  wire buf_word_t      rd_data,
   output logic [buf_aw-1:0]   rd_addr,
   output logic                ready,
   output logic                tx_en,
   output logic [3:0]          tx_data
);

   logic [2:0]          state;
   logic [3:0]          cnt;
   logic [nbytes_w-1:0] byte_cnt;
   logic [1:0]          sel_d;
   logic                hi;
   logic [3:0]          hi_nib;
   logic [31:0]         crc;
   logic [7:0]          cur_byte;

   // byte_cnt runs one byte ahead of the wire
   assign rd_addr  = byte_cnt[nbytes_w-1:2];
   assign cur_byte = rd_data.bytes[sel_d];

   // Byte select lines up with the registered memory read
   always_ff @(posedge tx_clk, posedge rst_int) begin
      if (rst_int)
         sel_d <= '0;
      else
         sel_d <= byte_cnt[1:0];
   end

   always_ff @(posedge tx_clk, posedge rst_int) begin
      if (rst_int) begin
         state    <= tx_st_idle;
         cnt      <= '0;
         byte_cnt <= '0;
         hi       <= 1'b0;
         hi_nib   <= '0;
         crc      <= '1;
         ready    <= 1'b1;
         tx_en    <= 1'b0;
         tx_data  <= '0;
      end else begin
         case (state)
            tx_st_idle: begin
               tx_en    <= 1'b0;
               ready    <= 1'b1;
               byte_cnt <= '0;
               if (send) begin
                  state <= tx_st_pre;
                  ready <= 1'b0;
                  cnt   <= '0;
                  crc   <= '1;
               end
            end
            tx_st_pre: begin
               // One lead cycle, then fifteen preamble nibbles
               if (cnt != 4'd0) begin
                  tx_en   <= 1'b1;
                  tx_data <= 4'h5;
               end
               cnt <= cnt + 1'b1;
               if (cnt == 4'd15)
                  state <= tx_st_sfd;
            end
            tx_st_sfd: begin
               tx_data <= 4'hd;
               hi      <= 1'b0;
               state   <= tx_st_data;
            end
            tx_st_data: begin
               hi <= ~hi;
               if (!hi) begin
                  // Keep the high nibble, the next fetch overwrites rd_data
                  tx_data  <= cur_byte[3:0];
                  hi_nib   <= cur_byte[7:4];
                  crc      <= crc32_nibble(crc, cur_byte[3:0]);
                  byte_cnt <= byte_cnt + 1'b1;
               end else begin
                  tx_data <= hi_nib;
                  crc     <= crc32_nibble(crc, hi_nib);
                  if (byte_cnt == nbytes) begin
                     state <= tx_st_fcs;
                     cnt   <= '0;
                  end
               end
            end
            tx_st_fcs: begin
               // Inverted CRC, least significant nibble first
               tx_data <= ~crc[4*cnt +: 4];
               cnt     <= cnt + 1'b1;
               if (cnt == 4'd7)
                  state <= tx_st_idle;
            end
            default: state <= tx_st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
rtl/eth_pkg.sv
rtl/eth_dp_mem.sv
rtl/eth_pulse_sync.sv
rtl/eth_regs.sv
rtl/eth_tx.sv
rtl/eth_rx.sv
rtl/eth_core.sv
dv/eth_core_tb.sv
